// File: files.f
+incdir+include
verilog/sram_pkg.sv
verilog/bram.sv
verilog/sram_bank.sv
verilog/sram_req_decode.sv
verilog/sram_rsp_merge.sv
verilog/sram.sv
sim/sram_tb.sv

// File: include/sram_params.svh
`ifndef SRAM_PARAMS_SVH
`define SRAM_PARAMS_SVH

// Byte address bits the memory decodes, 32 KB
`define SRAM_ADDR_W 15

// Port data width
`define SRAM_BUS_W 32

// Interleaved banks and the address bits that pick one
`define SRAM_NUM_BANKS 4
`define SRAM_BANK_SEL_W 2

// Byte offset inside a word
`define SRAM_OFF_W 2
`define SRAM_BE_W (`SRAM_BUS_W / 8)

// Word address left for each bank after offset and bank select
`define SRAM_BANK_ADDR_W (`SRAM_ADDR_W - `SRAM_OFF_W - `SRAM_BANK_SEL_W)

`endif

// File: sim/sram_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "sram_params.svh"

module sram_tb;

    localparam int MEM_BYTES     = 2 ** `SRAM_ADDR_W;
    // Word window that random traffic stays in, so loads hit earlier stores
    localparam int WINDOW_WORDS  = 64;
    localparam int RESET_CYCLES  = 4;
    localparam int DRAIN_TIMEOUT = 20;

    // One expected port response and the edge count when it must show
    typedef struct packed {
        logic        ack;
        logic        err;
        logic [31:0] rdata;
        logic [31:0] due;
    } expect_t;

    logic               clk;
    logic               rst_n;
    sram_pkg::bus_req_t req;
    sram_pkg::bus_rsp_t rsp;

    integer      seed;
    logic [31:0] edge_cnt;
    // Byte image of the whole memory
    logic [7:0]  model [0:MEM_BYTES-1];
    expect_t     exp_q [$];

    sram uut (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .rsp   (rsp)
    );

    ////////////////////
    // Clock and edge count
    ////////////////////

    always #20 clk = ~clk;

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    ////////////////////
    // Failure reporting
    ////////////////////

    task automatic abort_run;
        $display("Verification failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic flag_mismatch(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic stall_abort(input string msg);
        $display("ERROR: %s", msg);
        abort_run();
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    function automatic int access_bytes(input sram_pkg::size_e size);
        if (size == sram_pkg::SIZE_BYTE) begin
            return 1;
        end else if (size == sram_pkg::SIZE_HALF) begin
            return 2;
        end
        return 4;
    endfunction

    // Applies one access to the byte image and builds its response
    task automatic model_access(input logic we, input sram_pkg::size_e size,
                                input logic [31:0] addr, input logic [31:0] wdata,
                                output expect_t e);
        int nb;
        nb = access_bytes(size);
        e  = '0;
        // Out of range or not aligned to its own size
        if (addr >= MEM_BYTES || (addr % nb) != 0) begin
            e.err = 1'b1;
        end else begin
            e.ack = 1'b1;
            for (int i = 0; i < nb; i++) begin
                if (we) begin
                    model[addr + i] = wdata[8*i +: 8];
                end else begin
                    e.rdata[8*i +: 8] = model[addr + i];
                end
            end
        end
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    // Drives one cycle of the port just after the rising edge
    task automatic issue(input logic stb, input logic we, input sram_pkg::size_e size,
                         input logic [31:0] addr, input logic [31:0] wdata);
        expect_t e;
        @(posedge clk);
        #2;
        req = '{stb: stb, we: we, size: size, addr: addr, wdata: wdata};
        if (stb) begin
            model_access(we, size, addr, wdata, e);
            // Accepted at the next edge, answer visible after the one after
            e.due = edge_cnt + 2;
            exp_q.push_back(e);
        end
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            issue(1'b0, 1'b0, sram_pkg::SIZE_BYTE, 32'h0, 32'h0);
        end
    endtask

    task automatic random_access(input logic force_stb);
        logic            stb;
        logic            we;
        sram_pkg::size_e size;
        logic [31:0]     addr;
        logic [31:0]     wdata;
        int              kind;
        int              pick;
        kind  = {$random(seed)} % 16;
        stb   = force_stb || (({$random(seed)} % 8) != 0);
        we    = ({$random(seed)} % 2) == 1;
        pick  = {$random(seed)} % 3;
        size  = sram_pkg::size_e'(pick[1:0]);
        addr  = 32'(({$random(seed)} % WINDOW_WORDS) * 4);
        if (kind < 12) begin
            // Aligned for its size
            if (size == sram_pkg::SIZE_BYTE) begin
                addr += {$random(seed)} % 4;
            end else if (size == sram_pkg::SIZE_HALF) begin
                addr += 2 * ({$random(seed)} % 2);
            end
        end else if (kind < 14) begin
            // Any offset, often misaligned
            addr += {$random(seed)} % 4;
        end else begin
            // One bit above the decoded space
            addr |= 32'h1 << (`SRAM_ADDR_W + {$random(seed)} % (32 - `SRAM_ADDR_W));
        end
        wdata = $random(seed);
        issue(stb, we, size, addr, wdata);
    endtask

    // Waits until every pending access has answered
    task automatic drain;
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited >= DRAIN_TIMEOUT) begin
                stall_abort("no response within timeout");
            end
            @(posedge clk);
            waited++;
        end
    endtask

    ////////////////////
    // Response monitor
    ////////////////////

    task automatic check_response;
        expect_t e;
        assert (!$isunknown({rsp.ack, rsp.err}))
            else flag_mismatch("ack or err is unknown");
        assert (!(rsp.ack && rsp.err))
            else flag_mismatch("ack and err high together");
        if (rsp.ack || rsp.err) begin
            assert (exp_q.size() > 0)
                else flag_mismatch("response with no access pending");
            e = exp_q.pop_front();
            assert (e.due == edge_cnt)
                else flag_mismatch($sformatf("response at edge %0d, expected at edge %0d",
                                             edge_cnt, e.due));
            assert (rsp.ack == e.ack && rsp.err == e.err)
                else flag_mismatch($sformatf("ack/err %0b/%0b, expected %0b/%0b",
                                             rsp.ack, rsp.err, e.ack, e.err));
            assert (rsp.rdata === e.rdata)
                else flag_mismatch($sformatf("rdata %08h, expected %08h",
                                             rsp.rdata, e.rdata));
        end else begin
            // Nothing on the port although an answer is due
            assert (!(exp_q.size() > 0 && exp_q[0].due <= edge_cnt))
                else flag_mismatch("expected response missing");
        end
    endtask

    // Sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (rst_n) begin
            check_response();
        end
    end

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        seed     = 32'h59765c04;
        clk      = 1'b0;
        rst_n    = 1'b0;
        edge_cnt = '0;
        req      = '0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            model[i] = 8'h00;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Quiet port after reset
        idle_cycles(8);

        // Word stores across all four banks, then loads
        for (int w = 0; w < 4; w++) begin
            issue(1'b1, 1'b1, sram_pkg::SIZE_WORD, 32'(w * 4), 32'h1111_1111 * (w + 1));
        end
        for (int w = 0; w < 4; w++) begin
            issue(1'b1, 1'b0, sram_pkg::SIZE_WORD, 32'(w * 4), 32'h0);
        end

        // Byte lanes with junk above the byte
        for (int b = 0; b < 4; b++) begin
            issue(1'b1, 1'b1, sram_pkg::SIZE_BYTE, 32'(16 + b), 32'hcafe_0080 + b);
        end
        for (int b = 0; b < 4; b++) begin
            issue(1'b1, 1'b0, sram_pkg::SIZE_BYTE, 32'(16 + b), 32'hffff_ffff);
        end
        issue(1'b1, 1'b0, sram_pkg::SIZE_HALF, 32'd16, 32'h0);
        issue(1'b1, 1'b0, sram_pkg::SIZE_HALF, 32'd18, 32'h0);

        // Half stores in both halves of one word
        issue(1'b1, 1'b1, sram_pkg::SIZE_HALF, 32'd20, 32'h1234_beef);
        issue(1'b1, 1'b1, sram_pkg::SIZE_HALF, 32'd22, 32'h5678_c0de);
        issue(1'b1, 1'b0, sram_pkg::SIZE_WORD, 32'd20, 32'h0);
        issue(1'b1, 1'b0, sram_pkg::SIZE_BYTE, 32'd23, 32'h0);

        // Misaligned accesses, word 16 must stay intact
        issue(1'b1, 1'b1, sram_pkg::SIZE_HALF, 32'd17, 32'hdead_dead);
        issue(1'b1, 1'b1, sram_pkg::SIZE_WORD, 32'd18, 32'hdead_dead);
        issue(1'b1, 1'b0, sram_pkg::SIZE_WORD, 32'd21, 32'h0);
        issue(1'b1, 1'b0, sram_pkg::SIZE_HALF, 32'd23, 32'h0);
        issue(1'b1, 1'b0, sram_pkg::SIZE_WORD, 32'd16, 32'h0);

        // Out of range, aliases of words 4 and 16 must stay intact
        issue(1'b1, 1'b1, sram_pkg::SIZE_WORD, 32'h0000_8010, 32'hbad0_bad0);
        issue(1'b1, 1'b1, sram_pkg::SIZE_BYTE, 32'h8000_0004, 32'h0000_00ee);
        issue(1'b1, 1'b0, sram_pkg::SIZE_WORD, 32'h0001_0000, 32'h0);
        issue(1'b1, 1'b0, sram_pkg::SIZE_WORD, 32'd16, 32'h0);
        issue(1'b1, 1'b0, sram_pkg::SIZE_WORD, 32'd4, 32'h0);

        // Last word of the memory
        issue(1'b1, 1'b1, sram_pkg::SIZE_WORD, 32'(MEM_BYTES - 4), 32'h7654_3210);
        issue(1'b1, 1'b0, sram_pkg::SIZE_HALF, 32'(MEM_BYTES - 2), 32'h0);
        idle_cycles(4);

        // Random traffic with gaps, then a solid burst
        for (int i = 0; i < 300; i++) begin
            random_access(1'b0);
        end
        for (int i = 0; i < 200; i++) begin
            random_access(1'b1);
        end

        // Final sweep over the window
        for (int w = 0; w < WINDOW_WORDS; w++) begin
            issue(1'b1, 1'b0, sram_pkg::SIZE_WORD, 32'(w * 4), 32'h0);
        end
        idle_cycles(1);
        drain();
        idle_cycles(4);

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/bram.sv
`timescale 1ns/10ps
`default_nettype none

module bram #(
    parameter RAM_ADDR_WIDTH = 11,
    parameter RAM_BUS_WIDTH  = 32
) (
    input  wire logic                      clk,
    input  wire logic                      rd,
    input  wire logic [3:0]                we,
    input  wire logic [RAM_ADDR_WIDTH-1:0] addr,
    input  wire logic [RAM_BUS_WIDTH-1:0]  data,
    output      logic [RAM_BUS_WIDTH-1:0]  out
);

    localparam DEPTH = 2 ** RAM_ADDR_WIDTH;
    localparam LANES = RAM_BUS_WIDTH / 8;

    ////////////////////
    // Storage
    ////////////////////

    logic [RAM_BUS_WIDTH-1:0] mem [0:DEPTH-1];

    // Start from a cleared memory
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    ////////////////////
    // Port
    ////////////////////

    always_ff @(posedge clk) begin
        // Byte lane writes
        for (int b = 0; b < LANES; b++) begin
            if (we[b]) begin
                mem[addr][b*8 +: 8] <= data[b*8 +: 8];
            end
        end
        // Registered read, holds last word when idle
        if (rd) begin
            out <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: verilog/sram.sv
`timescale 1ns/10ps
`default_nettype none
`include "sram_params.svh"

module sram (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire sram_pkg::bus_req_t req,
    output      sram_pkg::bus_rsp_t rsp
);

    // Decoder to banks
    sram_pkg::bank_req_t bank_req [`SRAM_NUM_BANKS];
    // Banks to merger
    sram_pkg::bank_rsp_t bank_rsp [`SRAM_NUM_BANKS];
    // Access state, decoder to merger
    sram_pkg::rsp_tag_t  tag;

    ////////////////////
    // Request side
    ////////////////////

    sram_req_decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .bank_req (bank_req),
        .tag      (tag)
    );

    ////////////////////
    // Word-interleaved banks
    ////////////////////

    for (genvar b = 0; b < `SRAM_NUM_BANKS; b++) begin : g_bank
        sram_bank #(
            .ADDR_W (`SRAM_BANK_ADDR_W),
            .DATA_W (`SRAM_BUS_W)
        ) u_bank (
            .clk   (clk),
            .rst_n (rst_n),
            .req   (bank_req[b]),
            .rsp   (bank_rsp[b])
        );
    end

    ////////////////////
    // Response side
    ////////////////////

    sram_rsp_merge u_merge (
        .clk      (clk),
        .rst_n    (rst_n),
        .tag      (tag),
        .bank_rsp (bank_rsp),
        .rsp      (rsp)
    );

endmodule

`default_nettype wire

// File: verilog/sram_bank.sv
`timescale 1ns/10ps
`default_nettype none
`include "sram_params.svh"

module sram_bank #(
    // Word address bits of this bank
    parameter ADDR_W = `SRAM_BANK_ADDR_W,
    // Data bits per word
    parameter DATA_W = `SRAM_BUS_W
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire sram_pkg::bank_req_t req,
    output      sram_pkg::bank_rsp_t rsp
);

    logic              ram_rd;
    logic [3:0]        ram_we;
    logic [ADDR_W-1:0] ram_addr;
    logic [DATA_W-1:0] ram_wdata;
    logic [DATA_W-1:0] ram_out;
    logic              rsp_valid;

    ////////////////////
    // RAM request
    ////////////////////

    // Read only for a valid load
    assign ram_rd    = req.valid && !req.we;
    // Lanes stay quiet unless a store is addressed here
    assign ram_we    = (req.valid && req.we) ? req.be : 4'b0000;
    assign ram_addr  = req.addr;
    assign ram_wdata = req.wdata;

    bram #(
        .RAM_ADDR_WIDTH (ADDR_W),
        .RAM_BUS_WIDTH  (DATA_W)
    ) ram (
        .clk  (clk),
        .rd   (ram_rd),
        .we   (ram_we),
        .addr (ram_addr),
        .data (ram_wdata),
        .out  (ram_out)
    );

    ////////////////////
    // Response valid
    ////////////////////

    // Registered on the same edge as the RAM read word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req.valid;
        end
    end

    assign rsp = '{valid: rsp_valid, rdata: ram_out};

    // Decoder never sends an empty store
    a_store_has_lanes: assert property (
        @(posedge clk) disable iff (!rst_n)
        req.valid && req.we |-> req.be != '0
    );

endmodule

`default_nettype wire

// File: verilog/sram_pkg.sv
`default_nettype none
`include "sram_params.svh"

package sram_pkg;

    // Access size as the CPU encodes it
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } size_e;

    // One access offered on the data port
    typedef struct packed {
        logic                   stb;
        logic                   we;
        size_e                  size;
        // Full byte address, upper bits checked for range
        logic [`SRAM_BUS_W-1:0] addr;
        logic [`SRAM_BUS_W-1:0] wdata;
    } bus_req_t;

    // Port response, one per accepted access
    typedef struct packed {
        logic                   ack;
        logic                   err;
        logic [`SRAM_BUS_W-1:0] rdata;
    } bus_rsp_t;

    // Request into a single bank
    typedef struct packed {
        logic                         valid;
        logic                         we;
        logic [`SRAM_BE_W-1:0]        be;
        logic [`SRAM_BANK_ADDR_W-1:0] addr;
        // Already shifted into its byte lanes
        logic [`SRAM_BUS_W-1:0]       wdata;
    } bank_req_t;

    // Registered bank output
    typedef struct packed {
        logic                   valid;
        logic [`SRAM_BUS_W-1:0] rdata;
    } bank_rsp_t;

    // Access state carried alongside the bank pipeline
    typedef struct packed {
        logic                        valid;
        logic                        err;
        logic                        we;
        size_e                       size;
        logic [`SRAM_BANK_SEL_W-1:0] bank;
        logic [`SRAM_OFF_W-1:0]      offset;
    } rsp_tag_t;

endpackage

`default_nettype wire

// File: verilog/sram_req_decode.sv
`timescale 1ns/10ps
`default_nettype none
`include "sram_params.svh"

module sram_req_decode (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire sram_pkg::bus_req_t  req,
    output      sram_pkg::bank_req_t bank_req [`SRAM_NUM_BANKS],
    output      sram_pkg::rsp_tag_t  tag
);

    logic [`SRAM_OFF_W-1:0]       offset;
    logic [`SRAM_BANK_SEL_W-1:0]  bank_sel;
    logic [`SRAM_BANK_ADDR_W-1:0] word_addr;
    logic                         out_of_range;
    logic                         misaligned;
    logic                         err;
    logic [`SRAM_BE_W-1:0]        be;
    logic [`SRAM_BUS_W-1:0]       wdata_lane;
    logic [`SRAM_NUM_BANKS-1:0]   bank_hit;

    // Registered bank valids, one per bank
    logic [`SRAM_NUM_BANKS-1:0]   bank_valid_q;
    // Payload shared by all banks
    logic                         we_q;
    logic [`SRAM_BE_W-1:0]        be_q;
    logic [`SRAM_BANK_ADDR_W-1:0] addr_q;
    logic [`SRAM_BUS_W-1:0]       wdata_q;
    sram_pkg::rsp_tag_t           tag_q;

    ////////////////////
    // Address split
    ////////////////////

    // Low word bits interleave across banks
    assign offset    = req.addr[`SRAM_OFF_W-1:0];
    assign bank_sel  = req.addr[`SRAM_OFF_W +: `SRAM_BANK_SEL_W];
    assign word_addr = req.addr[`SRAM_OFF_W + `SRAM_BANK_SEL_W +: `SRAM_BANK_ADDR_W];

    // Anything above the decoded space
    assign out_of_range = |req.addr[`SRAM_BUS_W-1:`SRAM_ADDR_W];

    ////////////////////
    // Size handling
    ////////////////////

    always_comb begin
        case (req.size)
            sram_pkg::SIZE_BYTE: begin
                misaligned = 1'b0;
                be         = `SRAM_BE_W'(4'b0001) << offset;
            end
            sram_pkg::SIZE_HALF: begin
                misaligned = offset[0];
                be         = `SRAM_BE_W'(4'b0011) << offset;
            end
            sram_pkg::SIZE_WORD: begin
                misaligned = offset != '0;
                be         = '1;
            end
            default: begin
                // Reserved size code, rejected like a bad alignment
                misaligned = 1'b1;
                be         = '0;
            end
        endcase
    end

    assign err = out_of_range || misaligned;

    // Move store data up to its byte lanes
    assign wdata_lane = req.wdata << {offset, 3'b000};

    // One-hot bank select, empty on error or idle
    assign bank_hit = (req.stb && !err)
                    ? (`SRAM_NUM_BANKS'(1) << bank_sel)
                    : '0;

    ////////////////////
    // Pipeline register
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bank_valid_q <= '0;
            tag_q        <= '0;
        end else begin
            bank_valid_q <= bank_hit;
            tag_q        <= '{valid: req.stb, err: err, we: req.we, size: req.size,
                              bank: bank_sel, offset: offset};
        end
    end

    // Data path, loaded every cycle
    always_ff @(posedge clk) begin
        we_q    <= req.we;
        be_q    <= be;
        addr_q  <= word_addr;
        wdata_q <= wdata_lane;
    end

    always_comb begin
        for (int b = 0; b < `SRAM_NUM_BANKS; b++) begin
            bank_req[b] = '{valid: bank_valid_q[b], we: we_q, be: be_q,
                            addr: addr_q, wdata: wdata_q};
        end
    end

    assign tag = tag_q;

    // Single bank per access
    a_one_bank: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(bank_valid_q)
    );

    // Every bank access has a tag to finish it
    a_tag_with_bank: assert property (
        @(posedge clk) disable iff (!rst_n) |bank_valid_q |-> tag.valid && !tag.err
    );

endmodule

`default_nettype wire

// File: verilog/sram_rsp_merge.sv
`timescale 1ns/10ps
`default_nettype none
`include "sram_params.svh"

module sram_rsp_merge (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire sram_pkg::rsp_tag_t  tag,
    input  wire sram_pkg::bank_rsp_t bank_rsp [`SRAM_NUM_BANKS],
    output      sram_pkg::bus_rsp_t  rsp
);

    sram_pkg::rsp_tag_t         tag_q;
    logic [`SRAM_NUM_BANKS-1:0] bank_valid;
    logic [`SRAM_BUS_W-1:0]     word;
    logic [`SRAM_BUS_W-1:0]     shifted;
    logic [`SRAM_BUS_W-1:0]     size_mask;
    logic                       ack;
    logic                       load;

    ////////////////////
    // Tag delay
    ////////////////////

    // Lines the tag up with the bank read register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tag_q <= '0;
        end else begin
            tag_q <= tag;
        end
    end

    ////////////////////
    // Load data
    ////////////////////

    always_comb begin
        for (int b = 0; b < `SRAM_NUM_BANKS; b++) begin
            bank_valid[b] = bank_rsp[b].valid;
        end
    end

    // Answering bank named by the tag
    assign word    = bank_rsp[tag_q.bank].rdata;
    // Right-align the addressed bytes
    assign shifted = word >> {tag_q.offset, 3'b000};

    // Mask above the access size gives zero extension
    always_comb begin
        case (tag_q.size)
            sram_pkg::SIZE_BYTE: size_mask = `SRAM_BUS_W'(8'hff);
            sram_pkg::SIZE_HALF: size_mask = `SRAM_BUS_W'(16'hffff);
            default:             size_mask = '1;
        endcase
    end

    assign ack  = tag_q.valid && !tag_q.err;
    assign load = ack && !tag_q.we;

    // Store and error responses carry zero data
    assign rsp = '{ack:   ack,
                   err:   tag_q.valid && tag_q.err,
                   rdata: load ? (shifted & size_mask) : '0};

    // Bank answers every good access on time
    a_bank_answers: assert property (
        @(posedge clk) disable iff (!rst_n) ack |-> bank_valid[tag_q.bank]
    );

    // Stray bank output means the pipelines drifted apart
    a_no_orphan: assert property (
        @(posedge clk) disable iff (!rst_n) |bank_valid |-> ack
    );

endmodule

`default_nettype wire
